/* logic/matmul_defines.svh */
// Matrix multiplier dimensions and fixed-point formats
// OUT = X (N x M, row-wise) times Y (M x K, column-wise)
// Accumulator and index widths are derived from these

`ifndef MATMUL_DEFINES_SVH
`define MATMUL_DEFINES_SVH

// Matrix dimensions
`define MM_N 2
`define MM_M 2
`define MM_K 2

// Operand formats, signed fixed point
`define MM_X_WIDTH 8
`define MM_X_FRAC 1
`define MM_Y_WIDTH 8
`define MM_Y_FRAC 1

// Output format after rounding and saturation
`define MM_OUT_WIDTH 16
`define MM_OUT_FRAC 0

// Accumulator, X width + Y width + ceil(log2 M)
`define MM_ACC_WIDTH 17
`define MM_ACC_FRAC 2

// Index counter widths
`define MM_ROW_W ($clog2(`MM_N))
`define MM_COL_W ($clog2(`MM_K))
`define MM_DOT_W ($clog2(`MM_M))

`endif

/* logic/matmul_pkg.sv */
// Matrix multiplier shared types
// Controller state and signed element formats

package matmul_pkg;

  `include "matmul_defines.svh"

  // Controller state
  typedef enum logic [1:0] {
    ST_IDLE    = 2'd0,
    ST_COMPUTE = 2'd1,
    ST_DONE    = 2'd2
  } mm_state_e;

  // Element of X
  typedef logic signed [`MM_X_WIDTH-1:0] x_elem_t;

  // Element of Y
  typedef logic signed [`MM_Y_WIDTH-1:0] y_elem_t;

  // Dot-product accumulator, wide enough for M full-scale products
  typedef logic signed [`MM_ACC_WIDTH-1:0] acc_t;

  // Rounded and saturated output element
  typedef logic signed [`MM_OUT_WIDTH-1:0] out_elem_t;

endpackage

/* logic/matmul_ctrl.sv */
// Matrix multiplier controller
// Joins the X and Y handshakes, runs the MAC sequence
// and holds the result until the output handshake

`timescale 1ns/100ps

module matmul_ctrl (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  x_valid,
  input  logic                  y_valid,
  input  logic                  all_last,
  input  logic                  out_ready,
  output logic                  x_ready,
  output logic                  y_ready,
  output logic                  accept,
  output logic                  step,
  output logic                  done_pulse,
  output matmul_pkg::mm_state_e state
);

  matmul_pkg::mm_state_e state_next;
  logic                  in_idle;

  assign in_idle = (state == matmul_pkg::ST_IDLE);

  // Joined handshake, each ready waits on the other valid
  assign x_ready = in_idle && y_valid;
  assign y_ready = in_idle && x_valid;
  assign accept  = in_idle && x_valid && y_valid;

  // One product per cycle for the whole compute phase
  assign step = (state == matmul_pkg::ST_COMPUTE);

  // Final term of the matrix, result buffer raises out_valid
  assign done_pulse = step && all_last;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= matmul_pkg::ST_IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      matmul_pkg::ST_IDLE: begin
        // Both operands taken on the same edge
        if (accept) begin
          state_next = matmul_pkg::ST_COMPUTE;
        end
      end
      matmul_pkg::ST_COMPUTE: begin
        if (all_last) begin
          state_next = matmul_pkg::ST_DONE;
        end
      end
      matmul_pkg::ST_DONE: begin
        // out_valid is high for the whole state
        // so out_ready here completes the transfer
        if (out_ready) begin
          state_next = matmul_pkg::ST_IDLE;
        end
      end
      default: begin
        state_next = matmul_pkg::ST_IDLE;
      end
    endcase
  end

endmodule

/* logic/matmul_index_counter.sv */
// Element index counter for the time-shared MAC
// Walks dot index innermost, then column, then row

`timescale 1ns/100ps

`include "matmul_defines.svh"

module matmul_index_counter (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 accept,
  input  logic                 step,
  output logic [`MM_DOT_W-1:0] dot_idx,
  output logic [`MM_COL_W-1:0] col_idx,
  output logic [`MM_ROW_W-1:0] row_idx,
  output logic                 dot_last,
  output logic                 all_last
);

  logic col_last;
  logic row_last;

  // Wrap points of each level
  assign dot_last = (dot_idx == `MM_DOT_W'(`MM_M - 1));
  assign col_last = (col_idx == `MM_COL_W'(`MM_K - 1));
  assign row_last = (row_idx == `MM_ROW_W'(`MM_N - 1));

  // Last product of the last output element
  assign all_last = dot_last && col_last && row_last;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dot_idx <= '0;
      col_idx <= '0;
      row_idx <= '0;
    end else if (accept) begin
      // New operand pair starts at OUT[0][0]
      dot_idx <= '0;
      col_idx <= '0;
      row_idx <= '0;
    end else if (step) begin
      if (!dot_last) begin
        dot_idx <= dot_idx + 1'b1;
      end else begin
        dot_idx <= '0;
        // Dot product done, move to next output element
        if (!col_last) begin
          col_idx <= col_idx + 1'b1;
        end else begin
          col_idx <= '0;
          if (!row_last) begin
            row_idx <= row_idx + 1'b1;
          end else begin
            row_idx <= '0;
          end
        end
      end
    end
  end

endmodule

/* logic/matmul_operand_regs.sv */
// Operand capture for the matrix multiplier
// Holds X and Y from the accept edge and picks
// the X[row][dot], Y[dot][col] pair for the MAC

`timescale 1ns/100ps

`include "matmul_defines.svh"

module matmul_operand_regs (
  input  logic                                     clk,
  input  logic                                     rst_n,
  input  logic                                     accept,
  input  matmul_pkg::x_elem_t [`MM_N*`MM_M-1:0]    x_data,
  input  matmul_pkg::y_elem_t [`MM_K*`MM_M-1:0]    y_data,
  input  logic                [`MM_ROW_W-1:0]      row_idx,
  input  logic                [`MM_COL_W-1:0]      col_idx,
  input  logic                [`MM_DOT_W-1:0]      dot_idx,
  output matmul_pkg::x_elem_t                      x_elem,
  output matmul_pkg::y_elem_t                      y_elem
);

  // Local copies, so the sender may move on after accept
  matmul_pkg::x_elem_t [`MM_N*`MM_M-1:0] x_q;
  matmul_pkg::y_elem_t [`MM_K*`MM_M-1:0] y_q;

  int unsigned x_sel;
  int unsigned y_sel;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      x_q <= '0;
      y_q <= '0;
    end else if (accept) begin
      x_q <= x_data;
      y_q <= y_data;
    end
  end

  // X is row-wise, element i*M+m is X[i][m]
  assign x_sel = row_idx * `MM_M + dot_idx;

  // Y is column-wise, element j*M+m is Y[m][j]
  // Column of Y is contiguous, no transpose needed
  assign y_sel = col_idx * `MM_M + dot_idx;

  always_comb begin
    x_elem = x_q[x_sel];
    y_elem = y_q[y_sel];
  end

endmodule

/* logic/matmul_mac.sv */
// Time-shared signed multiply-accumulate
// One product per step, dot product rounded half-up
// and saturated into the output format on its last term

`timescale 1ns/100ps

`include "matmul_defines.svh"

module matmul_mac (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  step,
  input  logic                  dot_idx_zero,
  input  logic                  dot_last,
  input  matmul_pkg::x_elem_t   x_elem,
  input  matmul_pkg::y_elem_t   y_elem,
  output matmul_pkg::out_elem_t result,
  output logic                  result_valid
);

  localparam int SHIFT = `MM_ACC_FRAC - `MM_OUT_FRAC;
  // One spare bit so the half-LSB add cannot wrap
  localparam int RND_W = `MM_ACC_WIDTH + 1;

  localparam logic signed [RND_W-1:0] SAT_MAX = RND_W'(2 ** (`MM_OUT_WIDTH - 1) - 1);
  localparam logic signed [RND_W-1:0] SAT_MIN = ~SAT_MAX;

  logic signed [`MM_X_WIDTH+`MM_Y_WIDTH-1:0] product;
  matmul_pkg::acc_t                          product_ext;
  matmul_pkg::acc_t                          acc_q;
  matmul_pkg::acc_t                          sum;
  logic signed [RND_W-1:0]                   sum_ext;
  logic signed [RND_W-1:0]                   rnd;

  assign product     = x_elem * y_elem;
  assign product_ext = product;

  // First term of a dot product restarts the sum
  assign sum = dot_idx_zero ? product_ext : acc_q + product_ext;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc_q <= '0;
    end else if (step) begin
      acc_q <= sum;
    end
  end

  assign sum_ext = sum;

  // Half an output LSB, then arithmetic shift to output fraction
  if (SHIFT > 0) begin : g_round
    localparam logic signed [RND_W-1:0] HALF = RND_W'(1) <<< (SHIFT - 1);
    assign rnd = (sum_ext + HALF) >>> SHIFT;
  end else begin : g_no_shift
    assign rnd = sum_ext;
  end

  // Clamp to the signed output range
  always_comb begin
    if (rnd > SAT_MAX) begin
      result = matmul_pkg::out_elem_t'(SAT_MAX);
    end else if (rnd < SAT_MIN) begin
      result = matmul_pkg::out_elem_t'(SAT_MIN);
    end else begin
      result = matmul_pkg::out_elem_t'(rnd);
    end
  end

  // Rounded value is final only on the last term
  assign result_valid = step && dot_last;

endmodule

/* logic/matmul_result_buf.sv */
// Output matrix buffer
// Registers each finished element by row and column
// and presents the full matrix on the out_valid channel

`timescale 1ns/100ps

`include "matmul_defines.svh"

module matmul_result_buf (
  input  logic                                     clk,
  input  logic                                     rst_n,
  input  logic                                     result_valid,
  input  matmul_pkg::out_elem_t                    result,
  input  logic                  [`MM_ROW_W-1:0]    row_idx,
  input  logic                  [`MM_COL_W-1:0]    col_idx,
  input  logic                                     done_pulse,
  input  logic                                     out_ready,
  output matmul_pkg::out_elem_t [`MM_N*`MM_K-1:0]  out_data,
  output logic                                     out_valid
);

  int unsigned wr_idx;

  // OUT is row-wise, element i*K+j is OUT[i][j]
  assign wr_idx = row_idx * `MM_K + col_idx;

  // Element store, holds its value after the handshake
  always_ff @(posedge clk) begin
    if (result_valid) begin
      out_data[wr_idx] <= result;
    end
  end

  // Set with the last element write, cleared on transfer
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (done_pulse) begin
      out_valid <= 1'b1;
    end else if (out_valid && out_ready) begin
      out_valid <= 1'b0;
    end
  end

endmodule

/* logic/matmul_top.sv */
// Fixed-point matrix multiplier, OUT = X * Y
// Joined X/Y input handshake, one shared MAC,
// rounded and saturated output on a valid/ready channel

`timescale 1ns/100ps

`include "matmul_defines.svh"

module matmul_top (
  input  logic                                     clk,
  input  logic                                     rst_n,
  input  matmul_pkg::x_elem_t   [`MM_N*`MM_M-1:0]  x_data,
  input  logic                                     x_valid,
  output logic                                     x_ready,
  input  matmul_pkg::y_elem_t   [`MM_K*`MM_M-1:0]  y_data,
  input  logic                                     y_valid,
  output logic                                     y_ready,
  output matmul_pkg::out_elem_t [`MM_N*`MM_K-1:0]  out_data,
  output logic                                     out_valid,
  input  logic                                     out_ready
);

  // Controller outputs
  logic                  accept;
  logic                  step;
  logic                  done_pulse;
  matmul_pkg::mm_state_e state;

  // Element indices
  logic [`MM_DOT_W-1:0] dot_idx;
  logic [`MM_COL_W-1:0] col_idx;
  logic [`MM_ROW_W-1:0] row_idx;
  logic                 dot_last;
  logic                 all_last;
  logic                 dot_idx_zero;

  // Datapath
  matmul_pkg::x_elem_t   x_elem;
  matmul_pkg::y_elem_t   y_elem;
  matmul_pkg::out_elem_t result;
  logic                  result_valid;

  // First term of each dot product
  assign dot_idx_zero = (dot_idx == '0);

  matmul_ctrl ctrl_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .x_valid    (x_valid),
    .y_valid    (y_valid),
    .all_last   (all_last),
    .out_ready  (out_ready),
    .x_ready    (x_ready),
    .y_ready    (y_ready),
    .accept     (accept),
    .step       (step),
    .done_pulse (done_pulse),
    .state      (state)
  );

  matmul_index_counter idx_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .accept   (accept),
    .step     (step),
    .dot_idx  (dot_idx),
    .col_idx  (col_idx),
    .row_idx  (row_idx),
    .dot_last (dot_last),
    .all_last (all_last)
  );

  matmul_operand_regs opnd_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .accept  (accept),
    .x_data  (x_data),
    .y_data  (y_data),
    .row_idx (row_idx),
    .col_idx (col_idx),
    .dot_idx (dot_idx),
    .x_elem  (x_elem),
    .y_elem  (y_elem)
  );

  matmul_mac mac_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .step         (step),
    .dot_idx_zero (dot_idx_zero),
    .dot_last     (dot_last),
    .x_elem       (x_elem),
    .y_elem       (y_elem),
    .result       (result),
    .result_valid (result_valid)
  );

  matmul_result_buf rbuf_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .result_valid (result_valid),
    .result       (result),
    .row_idx      (row_idx),
    .col_idx      (col_idx),
    .done_pulse   (done_pulse),
    .out_ready    (out_ready),
    .out_data     (out_data),
    .out_valid    (out_valid)
  );

endmodule

/* sim/matmul_properties.sv */
// Handshake and timing assertions for the matrix multiplier
// Bound into matmul_top

`timescale 1ns/100ps

`include "matmul_defines.svh"

module matmul_properties (
  input logic                                     clk,
  input logic                                     rst_n,
  input logic                                     accept,
  input logic                                     x_ready,
  input logic                                     y_ready,
  input logic                                     out_valid,
  input logic                                     out_ready,
  input matmul_pkg::out_elem_t [`MM_N*`MM_K-1:0]  out_data,
  input matmul_pkg::mm_state_e                    state
);

  localparam int LATENCY = `MM_N * `MM_K * `MM_M;

  int unsigned assert_errors = 0;

  // No input is taken while a result is pending
  a_no_ready_when_full: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid |-> !(x_ready || y_ready))
  else begin
    assert_errors++;
    $error("input ready while out_valid is high");
  end

  // Result held until the consumer takes it
  a_out_stable: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=> $stable(out_data))
  else begin
    assert_errors++;
    $error("out_data changed while stalled");
  end

  // One product per edge, so out_valid rises a fixed number of edges after accept
  a_latency: assert property (@(posedge clk) disable iff (!rst_n)
    accept |=> !out_valid [*LATENCY] ##1 out_valid)
  else begin
    assert_errors++;
    $error("out_valid latency after accept is wrong");
  end

  // Result buffer flag tracks the controller done state
  a_valid_in_done: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid == (state == matmul_pkg::ST_DONE))
  else begin
    assert_errors++;
    $error("out_valid does not match the controller done state");
  end

  a_reset_clear: assert property (@(posedge clk) !rst_n |=> !out_valid)
  else begin
    assert_errors++;
    $error("out_valid high after reset");
  end

endmodule

bind matmul_top matmul_properties props_i (
  .clk       (clk),
  .rst_n     (rst_n),
  .accept    (accept),
  .x_ready   (x_ready),
  .y_ready   (y_ready),
  .out_valid (out_valid),
  .out_ready (out_ready),
  .out_data  (out_data),
  .state     (state)
);

/* sim/matmul_tb.sv */
// Testbench for the fixed-point matrix multiplier
// Directed and random cases from a table, checked against a reference model

`timescale 1ns/100ps

`include "matmul_defines.svh"

module matmul_tb;

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 5;
  localparam int NUM_DIRECTED = 6;
  localparam int NUM_RANDOM   = 20;
  localparam int NUM_ROWS     = NUM_DIRECTED + NUM_RANDOM;
  localparam int NXM          = `MM_N * `MM_M;
  localparam int KXM          = `MM_K * `MM_M;
  localparam int NXK          = `MM_N * `MM_K;
  localparam int LATENCY      = `MM_N * `MM_K * `MM_M;
  localparam int MAX_SKEW     = 3;
  localparam int MAX_STALL    = 6;
  localparam int SHIFT        = `MM_ACC_FRAC - `MM_OUT_FRAC;
  localparam longint OUT_MAX  = (64'sd1 <<< (`MM_OUT_WIDTH - 1)) - 1;
  localparam longint OUT_MIN  = -OUT_MAX - 1;
  // Per case: skew, compute, stall and a few handshake cycles
  localparam longint WATCHDOG_NS = longint'(NUM_ROWS * (LATENCY + MAX_SKEW + MAX_STALL + 10)
                                   + RESET_CYCLES) * CLK_PERIOD;

  logic                                   clk = 1'b0;
  logic                                   rst_n;
  matmul_pkg::x_elem_t   [NXM-1:0]        x_data;
  logic                                   x_valid;
  logic                                   x_ready;
  matmul_pkg::y_elem_t   [KXM-1:0]        y_data;
  logic                                   y_valid;
  logic                                   y_ready;
  matmul_pkg::out_elem_t [NXK-1:0]        out_data;
  logic                                   out_valid;
  logic                                   out_ready;

  // Case table, skew > 0 delays y_valid and skew < 0 delays x_valid
  matmul_pkg::x_elem_t   [NXM-1:0] tbl_x [NUM_ROWS];
  matmul_pkg::y_elem_t   [KXM-1:0] tbl_y [NUM_ROWS];
  matmul_pkg::out_elem_t [NXK-1:0] tbl_exp [NUM_ROWS];
  int                              tbl_skew [NUM_ROWS];
  int                              tbl_stall [NUM_ROWS];

  matmul_top dut_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .x_data    (x_data),
    .x_valid   (x_valid),
    .x_ready   (x_ready),
    .y_data    (y_data),
    .y_valid   (y_valid),
    .y_ready   (y_ready),
    .out_data  (out_data),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check_elem(input string name, input matmul_pkg::out_elem_t actual,
                            input matmul_pkg::out_elem_t expected);
    if (actual !== expected) begin
      stop_on_error($sformatf("MISMATCH time=%0t %s expected=%0d actual=%0d",
                              $time, name, expected, actual));
    end
  endtask

  task automatic check_flag(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      stop_on_error($sformatf("MISMATCH time=%0t %s expected=%b actual=%b",
                              $time, name, expected, actual));
    end
  endtask

  task automatic check_count(input string name, input int actual, input int expected);
    if (actual != expected) begin
      stop_on_error($sformatf("MISMATCH time=%0t %s expected=%0d actual=%0d",
                              $time, name, expected, actual));
    end
  endtask

  // Exact dot product, half-up rounding to the output fraction, then clamp
  function automatic matmul_pkg::out_elem_t model_elem(input int r, input int i, input int j);
    longint sum;
    sum = 0;
    for (int m = 0; m < `MM_M; m++) begin
      sum += longint'(tbl_x[r][i*`MM_M+m]) * longint'(tbl_y[r][j*`MM_M+m]);
    end
    if (SHIFT > 0) begin
      sum = (sum + (64'sd1 <<< (SHIFT - 1))) >>> SHIFT;
    end
    if (sum > OUT_MAX) sum = OUT_MAX;
    if (sum < OUT_MIN) sum = OUT_MIN;
    return matmul_pkg::out_elem_t'(sum);
  endfunction

  // X in element order X00 X01 X10 X11, Y in order Y00 Y10 Y01 Y11
  task automatic load_row(input int r, input int x0, input int x1, input int x2, input int x3,
                          input int y0, input int y1, input int y2, input int y3,
                          input int skew, input int stall);
    tbl_x[r] = {matmul_pkg::x_elem_t'(x3), matmul_pkg::x_elem_t'(x2),
                matmul_pkg::x_elem_t'(x1), matmul_pkg::x_elem_t'(x0)};
    tbl_y[r] = {matmul_pkg::y_elem_t'(y3), matmul_pkg::y_elem_t'(y2),
                matmul_pkg::y_elem_t'(y1), matmul_pkg::y_elem_t'(y0)};
    tbl_skew[r]  = skew;
    tbl_stall[r] = stall;
  endtask

  task automatic build_table();
    load_row(0, 2, 0, 0, 2, 6, -4, 10, 3, 0, 0);
    load_row(1, 0, 0, 0, 0, -7, 12, 5, -128, 1, 2);
    load_row(2, 4, 6, -2, 8, 2, 4, -6, 10, 2, 0);
    // Sums of +-0.5 and +-1.5 land exactly on the half
    load_row(3, 2, 0, -2, 0, 1, 0, 3, 0, -3, 4);
    load_row(4, -128, -128, -128, -128, -128, -128, -128, -128, 0, 1);
    load_row(5, 127, 127, 127, 127, -128, -128, -128, -128, -1, 6);
    for (int r = NUM_DIRECTED; r < NUM_ROWS; r++) begin
      for (int e = 0; e < NXM; e++) tbl_x[r][e] = matmul_pkg::x_elem_t'($urandom());
      for (int e = 0; e < KXM; e++) tbl_y[r][e] = matmul_pkg::y_elem_t'($urandom());
      tbl_skew[r]  = int'($urandom_range(2 * MAX_SKEW)) - MAX_SKEW;
      tbl_stall[r] = int'($urandom_range(MAX_STALL));
    end
    for (int r = 0; r < NUM_ROWS; r++) begin
      for (int i = 0; i < `MM_N; i++) begin
        for (int j = 0; j < `MM_K; j++) tbl_exp[r][i*`MM_K+j] = model_elem(r, i, j);
      end
    end
  endtask

  task automatic tally_transfers(inout int x_xfers, inout int y_xfers);
    if (x_valid && x_ready) x_xfers++;
    if (y_valid && y_ready) y_xfers++;
  endtask

  task automatic check_output(input int r, input logic valid_exp);
    check_flag("out_valid", out_valid, valid_exp);
    check_flag("x_ready", x_ready, 1'b0);
    check_flag("y_ready", y_ready, 1'b0);
    for (int e = 0; e < NXK; e++) begin
      check_elem($sformatf("out_data[%0d]", e), out_data[e], tbl_exp[r][e]);
    end
  endtask

  task automatic run_case(input int r);
    int lead;
    int lat;
    int x_xfers;
    int y_xfers;
    lead = (tbl_skew[r] < 0) ? -tbl_skew[r] : tbl_skew[r];
    lat = 0;
    x_xfers = 0;
    y_xfers = 0;
    @(posedge clk);
    x_data  <= tbl_x[r];
    y_data  <= tbl_y[r];
    x_valid <= (tbl_skew[r] >= 0);
    y_valid <= (tbl_skew[r] <= 0);
    for (int k = 0; k < lead; k++) begin
      @(negedge clk);
      // Each ready mirrors the other valid, so a lone valid never transfers
      check_flag("x_ready", x_ready, y_valid);
      check_flag("y_ready", y_ready, x_valid);
      tally_transfers(x_xfers, y_xfers);
      @(posedge clk);
      if (k == lead - 1) begin
        x_valid <= 1'b1;
        y_valid <= 1'b1;
      end
    end
    @(negedge clk);
    check_flag("x_ready", x_ready, 1'b1);
    check_flag("y_ready", y_ready, 1'b1);
    tally_transfers(x_xfers, y_xfers);
    // Accept edge, inputs scrambled and left valid to probe for a second accept
    @(posedge clk);
    x_data <= ~tbl_x[r];
    y_data <= ~tbl_y[r];
    do begin
      @(negedge clk);
      lat++;
      tally_transfers(x_xfers, y_xfers);
      check_flag("x_ready", x_ready, 1'b0);
      check_flag("y_ready", y_ready, 1'b0);
      if (lat > LATENCY + 2) stop_on_error("out_valid did not rise after accept");
    end while (!out_valid);
    // Negedge count includes the half cycle after the last compute edge
    check_count("latency", lat, LATENCY + 1);
    check_output(r, 1'b1);
    repeat (tbl_stall[r]) begin
      @(negedge clk);
      tally_transfers(x_xfers, y_xfers);
      check_output(r, 1'b1);
    end
    @(posedge clk);
    out_ready <= 1'b1;
    x_valid   <= 1'b0;
    y_valid   <= 1'b0;
    @(posedge clk);
    out_ready <= 1'b0;
    @(negedge clk);
    check_output(r, 1'b0);
    check_count("x transfers", x_xfers, 1);
    check_count("y transfers", y_xfers, 1);
  endtask

  initial begin
    #(WATCHDOG_NS);
    stop_on_error("Watchdog expired before all cases finished");
  end

  always @(negedge clk) begin
    if (dut_i.props_i.assert_errors != 0) begin
      stop_on_error("Assertion failed in matmul_properties");
    end
  end

  initial begin
    void'($urandom(32'h6085));
    rst_n     = 1'b0;
    x_valid   = 1'b0;
    y_valid   = 1'b0;
    out_ready = 1'b0;
    x_data    = '0;
    y_data    = '0;
    build_table();
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_flag("out_valid", out_valid, 1'b0);
    for (int r = 0; r < NUM_ROWS; r++) run_case(r);
    if (dut_i.props_i.assert_errors != 0) begin
      $display("Assertion failures counted in matmul_properties");
      $display("Testbench failed");
      $fatal(1);
    end else begin
      $display("Testbench passed");
      $finish;
    end
  end

endmodule

/* verilog.f */
+incdir+logic
logic/matmul_pkg.sv
logic/matmul_ctrl.sv
logic/matmul_index_counter.sv
logic/matmul_operand_regs.sv
logic/matmul_mac.sv
logic/matmul_result_buf.sv
logic/matmul_top.sv
sim/matmul_properties.sv
sim/matmul_tb.sv
